/* src/sdram_pkg.sv */
/*
 * Shared types and constants for the AXI4-Lite to SDRAM subsystem.
 * The stored array is 4 banks x 16 rows x 64 columns; higher AXI address bits alias.
 * Command vectors are {cs, ras, cas, we}, all active low.
 */
package sdram_pkg;

    typedef logic [31:0] axi_addr_t;
    typedef logic [31:0] axi_data_t;
    typedef logic [3:0]  axi_strb_t;
    typedef logic [12:0] sdram_a_t;
    typedef logic [1:0]  sdram_ba_t;
    typedef logic [15:0] sdram_dq_t;
    typedef logic [1:0]  sdram_dqm_t;
    typedef logic [3:0]  sdram_cmd_t;
    typedef logic [2:0]  cyc_cnt_t;

    localparam int BANK_W   = 2;
    localparam int ROW_W    = 4;
    localparam int COL_W    = 6;
    localparam int COL_LSB  = 2;                    // word address starts above bit 1
    localparam int ROW_LSB  = COL_LSB + COL_W - 1;  // column bit 0 is implied
    localparam int BANK_LSB = ROW_LSB + ROW_W;

    typedef logic [ROW_W-1:0] row_t;
    typedef logic [COL_W-1:0] col_t;

    localparam cyc_cnt_t CAS_LAT   = 3'd2;
    localparam cyc_cnt_t BURST_LEN = 3'd2;
    localparam cyc_cnt_t INIT_WAIT = 3'd4;
    localparam sdram_a_t MODE_WORD = sdram_a_t'({CAS_LAT, 1'b0, BURST_LEN});

    localparam sdram_cmd_t CMD_NOP = 4'b1111;
    localparam sdram_cmd_t CMD_ACT = 4'b0011;
    localparam sdram_cmd_t CMD_RD  = 4'b0101;
    localparam sdram_cmd_t CMD_WR  = 4'b0100;
    localparam sdram_cmd_t CMD_LMR = 4'b0000;

    localparam logic [1:0] RESP_OKAY = 2'b00;

    typedef struct packed {
        logic       write;
        sdram_ba_t  bank;
        row_t       row;
        col_t       col;
        axi_data_t  wdata;
        axi_strb_t  strb;
    } mem_req_t;

    typedef struct packed {
        logic       write;
        axi_data_t  rdata;
    } mem_rsp_t;

    typedef enum logic [3:0] {
        INIT_WAIT_S,
        LOAD_MODE_S,
        IDLE_S,
        ACTIVATE_S,
        WRITE0_S,
        WRITE1_S,
        READ_S,
        READ_WAIT_S,
        DONE_S
    } seq_state_t;

endpackage

/* src/axil_req_in.sv */
/*
 * AXI4-Lite request capture. One write and one read slot; write wins when both are full.
 * All ready outputs stay low until the sequencer reports idle after init.
 */
module axil_req_in
    import sdram_pkg::*;
(
    input  logic      clk,
    input  logic      cke,
    input  axi_addr_t awaddr,
    input  logic      awvalid,
    output logic      awready,
    input  axi_data_t wdata,
    input  axi_strb_t wstrb,
    input  logic      wvalid,
    output logic      wready,
    input  axi_addr_t araddr,
    input  logic      arvalid,
    output logic      arready,
    output mem_req_t  req,
    output logic      req_valid,
    input  logic      req_ready
);
    logic      aw_flag;
    logic      w_flag;
    logic      ar_flag;
    logic      wr_pend;
    logic      req_fire;
    axi_addr_t aw_addr_q;
    axi_addr_t ar_addr_q;
    axi_addr_t sel_addr;
    axi_data_t w_data_q;
    axi_strb_t w_strb_q;

    assign wr_pend   = aw_flag & w_flag;
    assign req_valid = wr_pend | ar_flag;
    assign req_fire  = req_valid & req_ready;

    assign awready = ~aw_flag & req_ready & ~req_valid;
    assign wready  = ~w_flag & req_ready & ~req_valid;
    assign arready = ~ar_flag & ~aw_flag & ~w_flag & req_ready & ~req_valid;

    always_ff @(posedge clk or negedge cke) begin
        if (!cke) begin
            aw_flag <= 1'b0;
            w_flag  <= 1'b0;
            ar_flag <= 1'b0;
        end else begin
            if (awvalid && awready) begin
                aw_flag <= 1'b1;
            end else if (req_fire && wr_pend) begin
                aw_flag <= 1'b0;
            end
            if (wvalid && wready) begin
                w_flag <= 1'b1;
            end else if (req_fire && wr_pend) begin
                w_flag <= 1'b0;
            end
            if (arvalid && arready) begin
                ar_flag <= 1'b1;
            end else if (req_fire && !wr_pend) begin
                ar_flag <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (awvalid && awready) aw_addr_q <= awaddr;
        if (arvalid && arready) ar_addr_q <= araddr;
        if (wvalid && wready) begin
            w_data_q <= wdata;
            w_strb_q <= wstrb;
        end
    end

    assign sel_addr  = wr_pend ? aw_addr_q : ar_addr_q;

    assign req.write = wr_pend;
    assign req.bank  = sel_addr[BANK_LSB +: BANK_W];
    assign req.row   = sel_addr[ROW_LSB +: ROW_W];
    assign req.col   = {sel_addr[COL_LSB +: COL_W-1], 1'b0};  // even column, burst of two
    assign req.wdata = w_data_q;
    assign req.strb  = w_strb_q;

endmodule

/* src/sdram_cmd_seq.sv */
/*
 * SDRAM command sequencer. Waits INIT_WAIT cycles, loads the mode register once,
 * then runs one ACTIVE plus two-word burst per request. No refresh, no precharge.
 * Read sampling assumes the device runs at CAS_LAT.
 */
module sdram_cmd_seq
    import sdram_pkg::*;
(
    input  logic       clk,
    input  logic       cke,
    input  mem_req_t   req,
    input  logic       req_valid,
    output logic       req_ready,
    output mem_rsp_t   rsp,
    output logic       rsp_valid,
    input  logic       rsp_free,
    output logic       cs,
    output logic       ras,
    output logic       cas,
    output logic       we,
    output sdram_a_t   a,
    output sdram_ba_t  ba,
    output sdram_dqm_t dqm,
    inout  wire sdram_dq_t dq
);
    seq_state_t state;
    cyc_cnt_t   cnt;
    mem_req_t   req_q;
    sdram_dq_t  rd_lo;
    sdram_dq_t  rd_hi;
    sdram_cmd_t cmd;
    logic       dq_oe;
    sdram_dq_t  dq_out;

    assign req_ready = (state == IDLE_S);
    assign {cs, ras, cas, we} = cmd;
    assign dq = dq_oe ? dq_out : 'z;

    assign rsp.write = req_q.write;
    assign rsp.rdata = {rd_hi, rd_lo};

    always_comb begin
        cmd    = CMD_NOP;
        a      = '0;
        ba     = '0;
        dqm    = '0;
        dq_oe  = 1'b0;
        dq_out = '0;
        case (state)
            LOAD_MODE_S: begin
                cmd = CMD_LMR;
                a   = MODE_WORD;
            end
            ACTIVATE_S: begin
                cmd = CMD_ACT;
                a   = sdram_a_t'(req_q.row);
                ba  = req_q.bank;
            end
            WRITE0_S: begin
                cmd    = CMD_WR;
                a      = sdram_a_t'(req_q.col);
                ba     = req_q.bank;
                dqm    = req_q.strb[1:0];  // low halfword first
                dq_oe  = 1'b1;
                dq_out = req_q.wdata[15:0];
            end
            WRITE1_S: begin
                dqm    = req_q.strb[3:2];  // nop carrying burst word 2
                dq_oe  = 1'b1;
                dq_out = req_q.wdata[31:16];
            end
            READ_S: begin
                cmd = CMD_RD;
                a   = sdram_a_t'(req_q.col);
                ba  = req_q.bank;
                dqm = 2'b11;
            end
            default: ;
        endcase
    end

    always_ff @(posedge clk or negedge cke) begin
        if (!cke) begin
            state     <= INIT_WAIT_S;
            cnt       <= '0;
            rsp_valid <= 1'b0;
        end else begin
            rsp_valid <= 1'b0;
            case (state)
                INIT_WAIT_S: begin
                    cnt <= cnt + 1'b1;
                    if (cnt == INIT_WAIT - 1'b1) state <= LOAD_MODE_S;
                end
                LOAD_MODE_S: state <= IDLE_S;
                IDLE_S:      if (req_valid) state <= ACTIVATE_S;
                ACTIVATE_S:  state <= req_q.write ? WRITE0_S : READ_S;
                WRITE0_S:    state <= WRITE1_S;
                WRITE1_S: begin
                    state     <= DONE_S;
                    rsp_valid <= 1'b1;
                end
                READ_S: begin
                    state <= READ_WAIT_S;
                    cnt   <= 3'd1;  // cycles since the read edge
                end
                READ_WAIT_S: begin
                    cnt <= cnt + 1'b1;
                    if (cnt == CAS_LAT + 1'b1) begin
                        state     <= DONE_S;
                        rsp_valid <= 1'b1;
                    end
                end
                DONE_S:      if (rsp_free && !rsp_valid) state <= IDLE_S;
                default:     state <= INIT_WAIT_S;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (state == IDLE_S && req_valid) req_q <= req;
        if (state == READ_WAIT_S && cnt == CAS_LAT) rd_lo <= dq;
        if (state == READ_WAIT_S && cnt == CAS_LAT + 1'b1) rd_hi <= dq;
    end

endmodule

/* src/axil_resp_out.sv */
/*
 * One-entry response buffer feeding the AXI4-Lite B and R channels.
 * Responses are always OKAY.
 */
module axil_resp_out
    import sdram_pkg::*;
(
    input  logic       clk,
    input  logic       cke,
    input  mem_rsp_t   rsp,
    input  logic       rsp_valid,
    output logic       rsp_free,
    output logic       bvalid,
    input  logic       bready,
    output logic [1:0] bresp,
    output logic       rvalid,
    input  logic       rready,
    output axi_data_t  rdata,
    output logic [1:0] rresp
);
    logic     hold_valid;
    mem_rsp_t hold_q;

    assign rsp_free = ~hold_valid;
    assign bvalid   = hold_valid & hold_q.write;
    assign rvalid   = hold_valid & ~hold_q.write;
    assign rdata    = hold_q.rdata;
    assign bresp    = RESP_OKAY;
    assign rresp    = RESP_OKAY;

    always_ff @(posedge clk or negedge cke) begin
        if (!cke) begin
            hold_valid <= 1'b0;
        end else if (rsp_valid && rsp_free) begin
            hold_valid <= 1'b1;
        end else if ((bvalid && bready) || (rvalid && rready)) begin
            hold_valid <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (rsp_valid && rsp_free) hold_q <= rsp;
    end

endmodule

/* src/sdram_model.sv */
/*
 * Behavioral SDRAM, 4 banks x 16 rows x 64 columns of 16 bits.
 * dqm bit 1 enables its byte, the reverse of real parts. Only the last activated
 * bank takes READ/WRITE; others are ignored. No refresh or precharge.
 */
module sdram_model
    import sdram_pkg::*;
(
    input  logic       clk,
    input  logic       cke,
    input  logic       cs,
    input  logic       ras,
    input  logic       cas,
    input  logic       we,
    input  sdram_a_t   a,
    input  sdram_ba_t  ba,
    input  sdram_dqm_t dqm,
    inout  wire sdram_dq_t dq
);
    typedef enum logic [1:0] {
        M_IDLE,
        M_RD_WAIT,
        M_RD_DATA,
        M_WR_BURST
    } mdl_state_t;

    mdl_state_t state;
    cyc_cnt_t   cnt;
    cyc_cnt_t   cas_lat;
    cyc_cnt_t   burst_len;
    sdram_ba_t  act_bank;
    row_t       act_row;
    col_t       col;
    col_t       wr_col;
    logic       active_cmd;
    logic       read_cmd;
    logic       write_cmd;
    logic       loadm_cmd;
    logic       bank_hit;
    logic       wr_en;
    sdram_dq_t  mem [2**BANK_W][2**ROW_W][2**COL_W];

    assign active_cmd = ({cs, ras, cas, we} == CMD_ACT);
    assign read_cmd   = ({cs, ras, cas, we} == CMD_RD);
    assign write_cmd  = ({cs, ras, cas, we} == CMD_WR);
    assign loadm_cmd  = ({cs, ras, cas, we} == CMD_LMR);
    assign bank_hit   = (ba == act_bank);

    assign wr_en  = (state == M_WR_BURST) || (state == M_IDLE && write_cmd && bank_hit);
    assign wr_col = (state == M_WR_BURST) ? col : a[COL_W-1:0];
    assign dq     = (state == M_RD_DATA) ? mem[act_bank][act_row][col] : 'z;

    always_ff @(posedge clk or negedge cke) begin
        if (!cke) begin
            cas_lat   <= 3'd3;  // until LOAD MODE
            burst_len <= 3'd1;
            act_bank  <= '0;
            act_row   <= '0;
        end else begin
            if (loadm_cmd) begin
                cas_lat   <= a[6:4];
                burst_len <= a[2:0];
            end
            if (active_cmd) begin
                act_bank <= ba;
                act_row  <= a[ROW_W-1:0];
            end
        end
    end

    always_ff @(posedge clk or negedge cke) begin
        if (!cke) begin
            state <= M_IDLE;
            cnt   <= '0;
            col   <= '0;
        end else begin
            case (state)
                M_IDLE: begin
                    cnt <= 3'd1;
                    if (read_cmd && bank_hit) begin
                        col   <= a[COL_W-1:0];
                        state <= (cas_lat > 3'd1) ? M_RD_WAIT : M_RD_DATA;
                    end else if (write_cmd && bank_hit) begin
                        col <= a[COL_W-1:0] + 1'b1;  // first word stored now
                        if (burst_len > 3'd1) state <= M_WR_BURST;
                    end
                end
                M_RD_WAIT: begin
                    if (cnt == cas_lat - 1'b1) begin
                        state <= M_RD_DATA;
                        cnt   <= 3'd1;
                    end else begin
                        cnt <= cnt + 1'b1;
                    end
                end
                M_RD_DATA: begin
                    col <= col + 1'b1;
                    cnt <= cnt + 1'b1;
                    if (cnt == burst_len) state <= M_IDLE;
                end
                M_WR_BURST: begin
                    col <= col + 1'b1;
                    cnt <= cnt + 1'b1;
                    if (cnt == burst_len - 1'b1) state <= M_IDLE;
                end
                default: state <= M_IDLE;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (wr_en) begin
            if (dqm[0]) mem[act_bank][act_row][wr_col][7:0]  <= dq[7:0];
            if (dqm[1]) mem[act_bank][act_row][wr_col][15:8] <= dq[15:8];
        end
    end

endmodule

/* src/sdram_subsys_top.sv */
/*
 * AXI4-Lite slave in front of the behavioral SDRAM. One transaction in flight.
 * Requests are accepted only after the LOAD MODE sequence following cke.
 */
module sdram_subsys_top
    import sdram_pkg::*;
(
    input  logic       clk,
    input  logic       cke,
    input  axi_addr_t  awaddr,
    input  logic       awvalid,
    output logic       awready,
    input  axi_data_t  wdata,
    input  axi_strb_t  wstrb,
    input  logic       wvalid,
    output logic       wready,
    output logic       bvalid,
    input  logic       bready,
    output logic [1:0] bresp,
    input  axi_addr_t  araddr,
    input  logic       arvalid,
    output logic       arready,
    output logic       rvalid,
    input  logic       rready,
    output axi_data_t  rdata,
    output logic [1:0] rresp
);
    mem_req_t   req;
    logic       req_valid;
    logic       req_ready;
    mem_rsp_t   rsp;
    logic       rsp_valid;
    logic       rsp_free;
    logic       cs;
    logic       ras;
    logic       cas;
    logic       we;
    sdram_a_t   a;
    sdram_ba_t  ba;
    sdram_dqm_t dqm;
    wire sdram_dq_t dq;  // shared by sequencer and device

    axil_req_in i_req_in (
        .clk, .cke,
        .awaddr, .awvalid, .awready,
        .wdata, .wstrb, .wvalid, .wready,
        .araddr, .arvalid, .arready,
        .req, .req_valid, .req_ready
    );

    sdram_cmd_seq i_cmd_seq (
        .clk, .cke,
        .req, .req_valid, .req_ready,
        .rsp, .rsp_valid, .rsp_free,
        .cs, .ras, .cas, .we, .a, .ba, .dqm, .dq
    );

    axil_resp_out i_resp_out (
        .clk, .cke,
        .rsp, .rsp_valid, .rsp_free,
        .bvalid, .bready, .bresp,
        .rvalid, .rready, .rdata, .rresp
    );

    sdram_model i_sdram (
        .clk, .cke,
        .cs, .ras, .cas, .we, .a, .ba, .dqm, .dq
    );

endmodule

/* verif/tb_sdram_subsys.sv */
/*
 * Testbench for the AXI4-Lite SDRAM subsystem, one transaction at a time.
 * Reads only target words that hold a full-strobe write.
 */
module tb_sdram_subsys
    import sdram_pkg::*;
();
    timeunit 1ns;
    timeprecision 100ps;

    localparam int NUM_TRANS  = 99;  // 8 + 13 + 6 + 60 + 12
    localparam int MAX_CYCLES = 40 * NUM_TRANS + 200;

    logic       clk;
    logic       cke;
    axi_addr_t  awaddr;
    logic       awvalid;
    logic       awready;
    axi_data_t  wdata;
    axi_strb_t  wstrb;
    logic       wvalid;
    logic       wready;
    logic       bvalid;
    logic       bready;
    logic [1:0] bresp;
    axi_addr_t  araddr;
    logic       arvalid;
    logic       arready;
    logic       rvalid;
    logic       rready;
    axi_data_t  rdata;
    logic [1:0] rresp;

    axi_data_t  shadow [2048];  // indexed by AXI address bits 12:2
    axi_data_t  exp_q [$];
    axi_addr_t  written_q [$];
    int         errors;
    int         checks;
    int         cycles;

    sdram_subsys_top i_sdram_subsys_top (.*);

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    initial begin
        cycles = 0;
        while (cycles < MAX_CYCLES) begin
            @(posedge clk);
            cycles++;
        end
        $display("Error: run did not finish within %0d cycles", MAX_CYCLES);
        $display(">>> FAIL");
        $finish;
    end

    function automatic axi_data_t expect_read(axi_addr_t addr);
        return shadow[addr[12:2]];
    endfunction

    function automatic void record_write(axi_addr_t addr, axi_data_t data, axi_strb_t strb);
        for (int i = 0; i < 4; i++) begin
            if (strb[i]) begin
                shadow[addr[12:2]][8*i +: 8] = data[8*i +: 8];
            end
        end
        if (strb == 4'hf) written_q.push_back(addr);
    endfunction

    task automatic report_mismatch(string sig, axi_data_t got, axi_data_t exp);
        $display("** Error at %0t ns: %s = %h, expected %h", $time, sig, got, exp);
        errors++;
    endtask

    task automatic note_failure(string msg);
        $display("Error at %0t ns: %s", $time, msg);
        errors++;
    endtask

    // compare process, handshake completes on the following rising edge
    always @(negedge clk) begin
        axi_data_t exp;
        if (cke && rvalid && rready) begin
            checks++;
            if (exp_q.size() == 0) begin
                note_failure("read data arrived with no read outstanding");
            end else begin
                exp = exp_q.pop_front();
                if (rdata !== exp) report_mismatch("rdata", rdata, exp);
                if (rresp !== 2'b00) report_mismatch("rresp", 32'(rresp), 32'h0);
            end
        end
        if (cke && bvalid && bready) begin
            checks++;
            if (bresp !== 2'b00) report_mismatch("bresp", 32'(bresp), 32'h0);
        end
    end

    task automatic check_quiet();
        checks++;
        if (awready || wready || arready || bvalid || rvalid)
            note_failure("a ready or valid output is high during or just after reset");
    endtask

    task automatic send_aw(axi_addr_t addr);
        @(posedge clk);
        #1 awaddr = addr;
        awvalid = 1'b1;
        do @(negedge clk); while (!awready);
        @(posedge clk);
        #1 awvalid = 1'b0;
    endtask

    task automatic send_w(axi_data_t data, axi_strb_t strb);
        @(posedge clk);
        #1 wdata = data;
        wstrb = strb;
        wvalid = 1'b1;
        do @(negedge clk); while (!wready);
        @(posedge clk);
        #1 wvalid = 1'b0;
    endtask

    // order 0 is AW first, 1 is W first, 2 is both together
    task automatic axi_write(axi_addr_t addr, axi_data_t data, axi_strb_t strb,
                             int order, int stall);
        record_write(addr, data, strb);
        case (order)
            0: begin
                send_aw(addr);
                send_w(data, strb);
            end
            1: begin
                send_w(data, strb);
                send_aw(addr);
            end
            default: fork
                send_aw(addr);
                send_w(data, strb);
            join
        endcase
        do @(negedge clk); while (!bvalid);
        repeat (stall) begin
            @(negedge clk);
            checks++;
            if (!bvalid) note_failure("bvalid dropped before the handshake");
        end
        @(posedge clk);
        #1 bready = 1'b1;
        @(posedge clk);
        #1 bready = 1'b0;
    endtask

    task automatic axi_read(axi_addr_t addr, int stall);
        axi_data_t held;
        exp_q.push_back(expect_read(addr));
        @(posedge clk);
        #1 araddr = addr;
        arvalid = 1'b1;
        do @(negedge clk); while (!arready);
        @(posedge clk);
        #1 arvalid = 1'b0;
        do @(negedge clk); while (!rvalid);
        held = rdata;
        repeat (stall) begin
            @(negedge clk);
            checks++;
            if (!rvalid) note_failure("rvalid dropped before the handshake");
            if (rdata !== held) report_mismatch("rdata (held)", rdata, held);
        end
        @(posedge clk);
        #1 rready = 1'b1;
        @(posedge clk);
        #1 rready = 1'b0;
    endtask

    task automatic finish_test(string name, int errs_before);
        $display("test %-16s %s (%0d errors)", name,
                 (errors == errs_before) ? "ok" : "FAILED", errors - errs_before);
    endtask

    initial begin
        int        start;
        axi_addr_t addr;
        axi_strb_t strbs [6];
        axi_addr_t bp_addr [4];
        strbs = '{4'b0001, 4'b0010, 4'b0100, 4'b1000, 4'b0011, 4'b1100};
        bp_addr = '{32'h0000_0148, 32'h0000_07f0, 32'h0000_0c3c, 32'h0000_1a5c};
        void'($urandom(32'h402f_175a));
        errors = 0;
        checks = 0;
        foreach (shadow[i]) shadow[i] = '0;
        cke = 1'b0;
        awaddr = '0;
        awvalid = 1'b0;
        wdata = '0;
        wstrb = '0;
        wvalid = 1'b0;
        bready = 1'b0;
        araddr = '0;
        arvalid = 1'b0;
        rready = 1'b0;

        start = errors;
        repeat (3) begin  // reset held for 3 cycles
            @(posedge clk);
            #1 check_quiet();
        end
        cke = 1'b1;
        @(negedge clk);
        check_quiet();
        do @(negedge clk); while (!arready);
        finish_test("reset_init", start);

        start = errors;
        foreach (bp_addr[i]) axi_write(bp_addr[i] ^ 32'h0000_0804, $urandom, 4'hf, 0, 0);
        foreach (bp_addr[i]) axi_read(bp_addr[i] ^ 32'h0000_0804, 0);
        finish_test("basic_rw", start);

        start = errors;
        addr = 32'h0000_0a4c;
        axi_write(addr, 32'h1122_3344, 4'hf, 0, 0);
        foreach (strbs[i]) begin
            axi_write(addr, $urandom, strbs[i], 0, 0);
            axi_read(addr, 0);
        end
        finish_test("byte_strobes", start);

        start = errors;
        for (int order = 0; order < 3; order++) begin
            addr = 32'h0000_1234 + 32'(order * 64);
            axi_write(addr, $urandom, 4'hf, order, 0);
            axi_read(addr, 0);
        end
        finish_test("channel_order", start);

        start = errors;
        for (int n = 0; n < 60; n++) begin
            if ($urandom % 2 == 0) begin
                addr = axi_addr_t'($urandom % 2048) << 2;  // below 8 KiB
                axi_write(addr, $urandom, axi_strb_t'($urandom % 15 + 1), $urandom % 3, 0);
            end else begin
                axi_read(written_q[$urandom % written_q.size()], 0);
            end
        end
        finish_test("random_traffic", start);

        start = errors;
        foreach (bp_addr[i]) begin
            axi_write(bp_addr[i], $urandom, 4'hf, i % 3, $urandom % 11);
            axi_read(bp_addr[i], $urandom % 11);
        end
        foreach (bp_addr[i]) axi_read(bp_addr[i], 0);
        finish_test("back_pressure", start);

        repeat (4) @(posedge clk);
        if (exp_q.size() != 0) note_failure("some reads never returned data");
        $display("%0d checks, %0d errors, %0d cycles", checks, errors, cycles);
        if (errors == 0) begin
            $display(">>> PASS");
        end else begin
            $display(">>> FAIL");
        end
        $finish;
    end

endmodule

/* filelist.f */
src/sdram_pkg.sv
src/axil_req_in.sv
src/sdram_cmd_seq.sv
src/axil_resp_out.sv
src/sdram_model.sv
src/sdram_subsys_top.sv
verif/tb_sdram_subsys.sv

/* run_sim.sh */
#!/bin/sh
# Build the testbench with Verilator, run it, and take the verdict from the log.
set -e
cd "$(dirname "$0")"

verilator --binary --timing -Wno-fatal -f filelist.f \
    --top-module tb_sdram_subsys -o sim_tb

./obj_dir/sim_tb > sim.log 2>&1 || true
cat sim.log

if grep -qx '>>> PASS' sim.log; then
    exit 0
fi
exit 1
